/* common/noc_dir_pkg.sv */
// Router port directions

package noc_dir_pkg;

	// The five ports of a mesh router.
	localparam int NUM_PORTS = 5;

	// Width of a direction code.
	localparam int DIR_W = 3;

	// The codes below index the inputs and the outputs alike. Their numeric order is
	// also the cyclic order that the round-robin arbiters walk.
	localparam logic [DIR_W-1:0] DIR_N      = 3'd0; // North.
	localparam logic [DIR_W-1:0] DIR_S      = 3'd1; // South.
	localparam logic [DIR_W-1:0] DIR_W_PORT = 3'd2; // West, named apart from the width.
	localparam logic [DIR_W-1:0] DIR_E      = 3'd3; // East.
	localparam logic [DIR_W-1:0] DIR_L      = 3'd4; // Local processing element.

	// Codes 5 to 7 are unused. An arbiter pointer that resets to DIR_L hands the first
	// grant to North.

endpackage

/* common/noc_packet_pkg.sv */
// Packet and address format

package noc_packet_pkg;

	// One mesh coordinate, X or Y.
	localparam int COORD_W = 4;

	// A YX address packs Y in the high nibble and X in the low nibble.
	localparam int ADDR_W = 2 * COORD_W;

	// Every packet has a fixed length, and the header counts as one flit.
	localparam int PACKET_FLITS = 4;

	// Flit counter width. It must hold PACKET_FLITS-1.
	localparam int FLIT_CNT_W = 2;

	// Packet length never travels in a header. The trackers compare against
	// PACKET_FLITS-1 to find the tail flit.

endpackage

/* common/route_req_if.sv */
// Input to allocator request bus

interface route_req_if;

	import noc_dir_pkg::*;

	logic [NUM_PORTS-1:0] req_valid; // Input owns a route and has a flit ready.
	logic [NUM_PORTS-1:0][DIR_W-1:0] req_dir; // Output direction each input asks for.
	logic [NUM_PORTS-1:0] req_last; // The flit on offer is the tail flit.
	logic [NUM_PORTS-1:0] read; // Flit leaves its input buffer this cycle.

	// Input side of the bus.
	modport requester (
		output req_valid,
		output req_dir,
		output req_last,
		input  read
	);

	// Switch allocator side.
	modport allocator (
		input  req_valid,
		input  req_dir,
		input  req_last,
		output read
	);

endinterface

/* input_port/input_port_ctrl.sv */
// Input port route control

module input_port_ctrl (
	input  logic clk,
	input  logic arst_n_i,
	input  logic flit_valid_i,
	input  logic [noc_packet_pkg::ADDR_W-1:0] header_addr_i,
	input  logic [noc_packet_pkg::ADDR_W-1:0] router_pos_i,
	input  logic read_i,
	output logic req_valid_o,
	output logic [noc_dir_pkg::DIR_W-1:0] req_dir_o,
	output logic req_last_o
);

	import noc_dir_pkg::*;
	import noc_packet_pkg::*;

	logic [COORD_W-1:0] hdr_y; // Destination row.
	logic [COORD_W-1:0] hdr_x; // Destination column.
	logic [COORD_W-1:0] pos_y;
	logic [COORD_W-1:0] pos_x;
	logic [DIR_W-1:0] yx_dir; // Route of the header currently at the buffer head.

	logic held_q; // A packet owns a route.
	logic [DIR_W-1:0] route_q; // Next-hop register.
	logic [FLIT_CNT_W-1:0] cnt_q; // Flits already read from the held packet.

	logic load;
	logic last_read;

	assign hdr_y = header_addr_i[ADDR_W-1:COORD_W];
	assign hdr_x = header_addr_i[COORD_W-1:0];
	assign pos_y = router_pos_i[ADDR_W-1:COORD_W];
	assign pos_x = router_pos_i[COORD_W-1:0];

	// YX order: settle the row first, then the column.
	always_comb begin
		if (hdr_y < pos_y) begin
			yx_dir = DIR_N;
		end else if (hdr_y > pos_y) begin
			yx_dir = DIR_S;
		end else if (hdr_x < pos_x) begin
			yx_dir = DIR_W_PORT;
		end else if (hdr_x > pos_x) begin
			yx_dir = DIR_E;
		end else begin
			yx_dir = DIR_L; // Arrived, eject to the local core.
		end
	end

	assign load = !held_q && flit_valid_i; // Only a header can reach an idle port.
	assign last_read = read_i && req_last_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			held_q <= 1'b0;
			route_q <= DIR_L;
			cnt_q <= '0;
		end else begin
			if (load) begin
				held_q <= 1'b1;
				route_q <= yx_dir; // Kept for the whole packet.
			end else if (last_read) begin
				held_q <= 1'b0; // Idle again, the next header loads a cycle later.
			end

			if (last_read) begin
				cnt_q <= '0;
			end else if (read_i) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign req_valid_o = held_q && flit_valid_i; // An empty buffer stalls the packet.
	assign req_dir_o = route_q;
	assign req_last_o = held_q && (cnt_q == FLIT_CNT_W'(PACKET_FLITS - 1));

	// The allocator may only read a port that is asking.
	a_read_needs_req : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		read_i |-> req_valid_o
	);

endmodule

/* output_port/output_arbiter.sv */
// Round-robin packet lock arbiter

module output_arbiter (
	input  logic clk,
	input  logic arst_n_i,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0] req_i,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0] last_i,
	input  logic credit_i,
	output logic [noc_dir_pkg::NUM_PORTS-1:0] grant_o,
	output logic dec_o,
	output logic [noc_dir_pkg::DIR_W-1:0] mux_sel_o
);

	import noc_dir_pkg::*;

	logic locked_q; // Output belongs to one input until its tail flit.
	logic [DIR_W-1:0] owner_q; // Input holding the lock.
	logic [DIR_W-1:0] ptr_q; // Last input that took the lock.

	logic any_req;
	logic [DIR_W-1:0] winner;
	logic [DIR_W-1:0] eff_owner;
	logic fire;
	logic last_fire;

	// First requester after ptr in cyclic code order. The search runs from the far
	// end so that the nearest candidate is written last.
	function automatic logic [DIR_W-1:0] rr_pick(
		input logic [NUM_PORTS-1:0] req,
		input logic [DIR_W-1:0] ptr
	);
		logic [DIR_W-1:0] pick;
		int cand;
		pick = ptr;
		for (int k = NUM_PORTS; k >= 1; k--) begin
			cand = (int'(ptr) + k) % NUM_PORTS;
			if (req[cand]) begin
				pick = DIR_W'(cand);
			end
		end
		return pick;
	endfunction

	assign any_req = |req_i;
	assign winner = rr_pick(req_i, ptr_q);
	assign eff_owner = locked_q ? owner_q : winner;

	// A flit moves only when the owner has one ready and downstream has room.
	assign fire = (locked_q || any_req) && req_i[eff_owner] && credit_i;
	assign last_fire = fire && last_i[eff_owner];

	always_comb begin
		grant_o = '0;
		grant_o[eff_owner] = fire;
	end

	assign dec_o = fire; // One credit used per forwarded flit.
	assign mux_sel_o = eff_owner;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			locked_q <= 1'b0;
			owner_q <= DIR_L;
			ptr_q <= DIR_L; // North wins first.
		end else begin
			if (!locked_q && any_req) begin
				owner_q <= winner;
				ptr_q <= winner; // Winner drops to lowest priority.
			end
			locked_q <= (locked_q || any_req) && !last_fire;
		end
	end

	a_dec_has_credit : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		dec_o |-> credit_i
	);

	// After a flit that is not the tail, the output stays with the same input.
	a_lock_holds : assert property (
		@(posedge clk) disable iff (!arst_n_i)
		(dec_o && !last_i[mux_sel_o]) |=> (mux_sel_o == $past(mux_sel_o))
	);

endmodule

/* output_port/switch_allocator.sv */
// Switch allocator for all outputs

module switch_allocator (
	input  logic clk,
	input  logic arst_n_i,
	route_req_if.allocator req_if,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0] credit_i,
	output logic [noc_dir_pkg::NUM_PORTS-1:0] dec_o,
	output logic [noc_dir_pkg::NUM_PORTS-1:0][noc_dir_pkg::DIR_W-1:0] mux_sel_o
);

	import noc_dir_pkg::*;

	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_req; // [output][input]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_grant; // [output][input]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] in_grant; // Same grants, [input][output].

	// Each output sees only the inputs whose route points at it.
	always_comb begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				out_req[o][i] = req_if.req_valid[i] && (req_if.req_dir[i] == DIR_W'(o));
			end
		end
	end

	for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
		output_arbiter output_arbiter_inst (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.req_i     (out_req[o]),
			.last_i    (req_if.req_last),
			.credit_i  (credit_i[o]),
			.grant_o   (out_grant[o]),
			.dec_o     (dec_o[o]),
			.mux_sel_o (mux_sel_o[o])
		);
	end

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				in_grant[i][o] = out_grant[o][i];
			end
		end
	end

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
		assign req_if.read[i] = |in_grant[i]; // Any output that granted this input.

		// An input names one route, so two outputs must never pull the same flit.
		a_single_grant : assert property (
			@(posedge clk) disable iff (!arst_n_i)
			$onehot0(in_grant[i])
		);
	end

endmodule

/* src/noc_arbiter_top.sv */
// Mesh router switch control

module noc_arbiter_top (
	input  logic clk,
	input  logic arst_n_i,
	input  logic [noc_packet_pkg::ADDR_W-1:0] router_pos_i,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0] flit_valid_i,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0][noc_packet_pkg::ADDR_W-1:0] header_addr_i,
	input  logic [noc_dir_pkg::NUM_PORTS-1:0] credit_i,
	output logic [noc_dir_pkg::NUM_PORTS-1:0] read_o,
	output logic [noc_dir_pkg::NUM_PORTS-1:0][noc_dir_pkg::DIR_W-1:0] route_o,
	output logic [noc_dir_pkg::NUM_PORTS-1:0] dec_o,
	output logic [noc_dir_pkg::NUM_PORTS-1:0][noc_dir_pkg::DIR_W-1:0] mux_sel_o
);

	import noc_dir_pkg::*;

	route_req_if req_bus ();

	// One route controller per input buffer.
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
		input_port_ctrl input_port_ctrl_inst (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.flit_valid_i  (flit_valid_i[p]),
			.header_addr_i (header_addr_i[p]),
			.router_pos_i  (router_pos_i),
			.read_i        (req_bus.read[p]),
			.req_valid_o   (req_bus.req_valid[p]),
			.req_dir_o     (req_bus.req_dir[p]),
			.req_last_o    (req_bus.req_last[p])
		);
	end

	switch_allocator switch_allocator_inst (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.req_if    (req_bus.allocator),
		.credit_i  (credit_i),
		.dec_o     (dec_o),
		.mux_sel_o (mux_sel_o)
	);

	// Buffer read strobes and the crossbar demux addresses.
	assign read_o = req_bus.read;
	assign route_o = req_bus.req_dir;

endmodule

/* testbench/noc_arbiter_tb.sv */
// Switch control testbench

module noc_arbiter_tb;

	import noc_dir_pkg::*;
	import noc_packet_pkg::*;

	localparam logic [ADDR_W-1:0] ROUTER_POS = 8'h55; // Y = 5, X = 5.
	localparam int RANDOM_PACKETS = 40;
	localparam int RR_TIMEOUT = 400;
	localparam int DRAIN_TIMEOUT = 4000;

	logic clk;
	logic arst_n_i;
	logic [ADDR_W-1:0] router_pos_i;
	logic [NUM_PORTS-1:0] flit_valid_i;
	logic [NUM_PORTS-1:0][ADDR_W-1:0] header_addr_i;
	logic [NUM_PORTS-1:0] credit_i;
	logic [NUM_PORTS-1:0] read_o;
	logic [NUM_PORTS-1:0][DIR_W-1:0] route_o;
	logic [NUM_PORTS-1:0] dec_o;
	logic [NUM_PORTS-1:0][DIR_W-1:0] mux_sel_o;

	logic [ADDR_W-1:0] pkt_q [NUM_PORTS][$]; // Header address of each queued packet.
	int flits_done [NUM_PORTS]; // Flits already read from the head packet.
	logic [NUM_PORTS-1:0] reads_seen; // Reads of the cycle that just ended.
	int out_src [NUM_PORTS]; // Input that owns each output.
	int out_left [NUM_PORTS]; // Flits still due on each output.
	int start_log [$]; // Inputs in the order in which their packets started.
	int total_reads;
	int flits_queued;
	logic random_credit;
	logic [7:0] lfsr_state;

	noc_arbiter_top noc_arbiter_top_inst (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.router_pos_i  (router_pos_i),
		.flit_valid_i  (flit_valid_i),
		.header_addr_i (header_addr_i),
		.credit_i      (credit_i),
		.read_o        (read_o),
		.route_o       (route_o),
		.dec_o         (dec_o),
		.mux_sel_o     (mux_sel_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Expected output for a destination, row first and then column.
	function automatic logic [DIR_W-1:0] ref_yx_route(
		input logic [ADDR_W-1:0] dest,
		input logic [ADDR_W-1:0] pos
	);
		logic [DIR_W-1:0] dir;
		if (dest[ADDR_W-1:COORD_W] < pos[ADDR_W-1:COORD_W]) begin
			dir = DIR_N;
		end else if (dest[ADDR_W-1:COORD_W] > pos[ADDR_W-1:COORD_W]) begin
			dir = DIR_S;
		end else if (dest[COORD_W-1:0] < pos[COORD_W-1:0]) begin
			dir = DIR_W_PORT;
		end else if (dest[COORD_W-1:0] > pos[COORD_W-1:0]) begin
			dir = DIR_E;
		end else begin
			dir = DIR_L;
		end
		return dir;
	endfunction

	// Next winner after ptr, walking the direction codes upwards with wrap.
	function automatic int ref_rr_pick(input logic [NUM_PORTS-1:0] req, input int ptr);
		int pick;
		int idx;
		logic found;
		pick = ptr;
		found = 1'b0;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			idx = (ptr + k) % NUM_PORTS;
			if (!found && req[idx]) begin
				pick = idx;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	function automatic logic [7:0] lfsr_step(input logic [7:0] state);
		logic [7:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 8'hB8; // Taps 8, 6, 5, 4.
		end
		return next;
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] val);
		val = '0;
		for (int b = 0; b < count; b++) begin
			val = {val[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_dir(
		input string name,
		input logic [DIR_W-1:0] got,
		input logic [DIR_W-1:0] exp
	);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic queue_packet(input int port, input logic [ADDR_W-1:0] dest);
		pkt_q[port].push_back(dest);
		flits_queued += PACKET_FLITS;
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			#1;
			for (int p = 0; p < NUM_PORTS; p++) begin
				check_bit($sformatf("read_o[%0d]", p), read_o[p], 1'b0);
				check_bit($sformatf("dec_o[%0d]", p), dec_o[p], 1'b0);
			end
		end
	endtask

	task automatic wait_for_drain(input int limit, input string what);
		int cycles;
		logic busy;
		cycles = 0;
		busy = 1'b1;
		while (busy) begin
			@(negedge clk);
			#1;
			busy = 1'b0;
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (pkt_q[p].size() != 0 || out_left[p] != 0) begin
					busy = 1'b1;
				end
			end
			cycles++;
			if (busy && cycles > limit) begin
				stop_on_error($sformatf("Timeout: %s did not drain within %0d cycles", what, limit));
			end
		end
	endtask

	// Buffer and credit models, updated from the reads seen in the previous cycle.
	always @(posedge clk) begin : drive_model
		logic [7:0] bit_val;
		#2;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (reads_seen[i]) begin
				flits_done[i]++;
				if (flits_done[i] == PACKET_FLITS) begin
					void'(pkt_q[i].pop_front()); // Tail flit gone.
					flits_done[i] = 0;
				end
			end
			flit_valid_i[i] = pkt_q[i].size() > 0;
			header_addr_i[i] = (pkt_q[i].size() > 0) ? pkt_q[i][0] : '0;
		end
		reads_seen = '0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (random_credit) begin
				draw_bits(1, bit_val);
				credit_i[o] = bit_val[0];
			end else begin
				credit_i[o] = 1'b1;
			end
		end
	end

	always @(negedge clk) begin : compare_outputs
		logic [NUM_PORTS-1:0] claimed;
		logic [DIR_W-1:0] exp_dir;
		int src;
		if (!arst_n_i) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				check_bit($sformatf("read_o[%0d]", p), read_o[p], 1'b0);
				check_bit($sformatf("dec_o[%0d]", p), dec_o[p], 1'b0);
			end
		end else begin
			claimed = '0;
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (dec_o[o]) begin
					check_bit($sformatf("credit_i[%0d] under dec_o", o), credit_i[o], 1'b1);
					if (mux_sel_o[o] >= NUM_PORTS) begin
						stop_on_error($sformatf("Output %0d selects input code %0d, which does not exist",
							o, mux_sel_o[o]));
					end
					src = int'(mux_sel_o[o]);
					if (claimed[src]) begin
						stop_on_error($sformatf("Input %0d was taken by two outputs in one cycle", src));
					end
					claimed[src] = 1'b1;
					check_bit($sformatf("read_o[%0d]", src), read_o[src], 1'b1);
					check_bit($sformatf("flit_valid_i[%0d]", src), flit_valid_i[src], 1'b1);
					exp_dir = ref_yx_route(pkt_q[src][0], router_pos_i);
					check_dir($sformatf("route_o[%0d]", src), route_o[src], exp_dir);
					check_dir($sformatf("output used by input %0d", src), DIR_W'(o), exp_dir);
					if (out_left[o] == 0) begin
						if (flits_done[src] != 0) begin
							stop_on_error($sformatf("Output %0d started a packet in the middle of input %0d",
								o, src));
						end
						start_log.push_back(src);
						out_src[o] = src;
						out_left[o] = PACKET_FLITS - 1;
					end else begin
						check_dir($sformatf("mux_sel_o[%0d]", o), mux_sel_o[o], DIR_W'(out_src[o]));
						out_left[o]--;
					end
				end
			end
			for (int i = 0; i < NUM_PORTS; i++) begin
				check_bit($sformatf("read_o[%0d]", i), read_o[i], claimed[i]); // One dec per read.
			end
			reads_seen = read_o;
			total_reads += $countones(read_o);
		end
	end

	initial begin : run_tests
		int exp_order [$];
		int pending [NUM_PORTS];
		logic [NUM_PORTS-1:0] pending_req;
		logic [7:0] bit_val;
		logic [3:0] y_off;
		logic [3:0] x_off;
		int ptr;
		int pick;
		int port;

		arst_n_i = 1'b0;
		router_pos_i = ROUTER_POS;
		flit_valid_i = '0;
		header_addr_i = '0;
		credit_i = '1;
		reads_seen = '0;
		random_credit = 1'b0;
		lfsr_state = 8'd90;
		total_reads = 0;
		flits_queued = 0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			flits_done[p] = 0;
			out_src[p] = 0;
			out_left[p] = 0;
		end

		repeat (16) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		check_idle(4);

		// Four inputs compete for the local output, two packets each.
		@(negedge clk);
		#1;
		start_log.delete();
		for (int p = int'(DIR_N); p <= int'(DIR_E); p++) begin
			queue_packet(p, ROUTER_POS);
			queue_packet(p, ROUTER_POS);
			pending[p] = 2;
		end
		pending[DIR_L] = 0;
		wait_for_drain(RR_TIMEOUT, "round-robin traffic");
		ptr = int'(DIR_L);
		for (int n = 0; n < 8; n++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				pending_req[p] = pending[p] > 0;
			end
			pick = ref_rr_pick(pending_req, ptr);
			exp_order.push_back(pick);
			pending[pick]--;
			ptr = pick;
		end
		if (start_log.size() != exp_order.size()) begin
			stop_on_error($sformatf("Round-robin test saw %0d packet starts instead of %0d",
				start_log.size(), exp_order.size()));
		end
		for (int n = 0; n < exp_order.size(); n++) begin
			check_dir($sformatf("packet start %0d input", n), DIR_W'(start_log[n]),
				DIR_W'(exp_order[n]));
		end
		check_idle(4);

		// Random destinations near the router so that every direction occurs.
		random_credit = 1'b1;
		for (int n = 0; n < RANDOM_PACKETS; n++) begin
			draw_bits(3, bit_val);
			port = int'(bit_val) % NUM_PORTS;
			draw_bits(2, bit_val);
			y_off = bit_val[3:0];
			draw_bits(2, bit_val);
			x_off = bit_val[3:0];
			queue_packet(port, {4'd4 + y_off, 4'd4 + x_off});
		end
		wait_for_drain(DRAIN_TIMEOUT, "random traffic");
		if (total_reads != flits_queued) begin
			stop_on_error($sformatf("Read %0d flits but %0d were queued", total_reads, flits_queued));
		end
		check_idle(8); // All outputs unlocked and every port quiet.

		$display("All tests passed!");
		$finish;
	end

endmodule

/* noc_arbiter.f */
common/noc_dir_pkg.sv
common/noc_packet_pkg.sv
common/route_req_if.sv
input_port/input_port_ctrl.sv
output_port/output_arbiter.sv
output_port/switch_allocator.sv
src/noc_arbiter_top.sv
testbench/noc_arbiter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module noc_arbiter_tb \
	-f noc_arbiter.f \
	-o noc_arbiter_sim

./obj_dir/noc_arbiter_sim | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi

echo "Simulation passed"
